//--- common/mem_bus_pkg.sv
`default_nettype none

package mem_bus_pkg;

    // Lane word widths
    localparam int ADDR_WIDTH   = 32;
    localparam int DATA_WIDTH   = 32;
    localparam int TAG_WIDTH    = 8;
    localparam int BYTEEN_WIDTH = DATA_WIDTH / 8;

    typedef logic [ADDR_WIDTH-1:0]   addr_t;
    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [BYTEEN_WIDTH-1:0] byteen_t;
    typedef logic [TAG_WIDTH-1:0]    tag_t;

    // One opcode for all lanes of a request
    typedef enum logic {
        MEM_READ  = 1'b0,
        MEM_WRITE = 1'b1
    } mem_op_e;

endpackage

`default_nettype wire

//--- common/sched_cfg_pkg.sv
`default_nettype none

package sched_cfg_pkg;

    // Lanes per caller request
    localparam int DEF_NUM_REQS = 6;

    // Six lanes over four banks gives a full batch and a partial one
    localparam int DEF_NUM_BANKS = 4;

    // Queue entries, also the number of read slots
    localparam int DEF_QUEUE_SIZE = 4;

endpackage

`default_nettype wire

//--- common/sched_req_if.sv
`default_nettype none

interface sched_req_if #(
    parameter int NUM_REQS   = sched_cfg_pkg::DEF_NUM_REQS,
    parameter int QUEUE_SIZE = sched_cfg_pkg::DEF_QUEUE_SIZE
);
    import mem_bus_pkg::*;

    localparam int SLOT_BITS = (QUEUE_SIZE > 1) ? $clog2(QUEUE_SIZE) : 1;

    // Head entry of the request queue
    logic                       valid;
    mem_op_e                    op;
    logic [NUM_REQS-1:0]        mask;
    byteen_t [NUM_REQS-1:0]     byteen;
    addr_t [NUM_REQS-1:0]       addr;
    data_t [NUM_REQS-1:0]       data;
    logic [SLOT_BITS-1:0]       slot;
    // Issuer is done with the head
    logic                       pop;

    modport queue (output valid, op, mask, byteen, addr, data, slot, input pop);
    modport issuer (input valid, op, mask, byteen, addr, data, slot, output pop);

endinterface

`default_nettype wire

//--- flist.f
common/mem_bus_pkg.sv
common/sched_cfg_pkg.sv
common/sched_req_if.sv
request/req_queue.sv
request/batch_issuer.sv
response/slot_table.sv
response/rsp_gather.sv
source/mem_scheduler.sv
verif/mem_scheduler_tb.sv

//--- request/batch_issuer.sv
`default_nettype none

module batch_issuer #(
    parameter int NUM_REQS    = sched_cfg_pkg::DEF_NUM_REQS,
    parameter int NUM_BANKS   = sched_cfg_pkg::DEF_NUM_BANKS,
    parameter int QUEUE_SIZE  = sched_cfg_pkg::DEF_QUEUE_SIZE,
    localparam int NUM_BATCHES = (NUM_REQS + NUM_BANKS - 1) / NUM_BANKS,
    localparam int SLOT_BITS   = (QUEUE_SIZE > 1) ? $clog2(QUEUE_SIZE) : 1,
    localparam int BATCH_BITS  = (NUM_BATCHES > 1) ? $clog2(NUM_BATCHES) : 1,
    localparam int MEM_TAGW    = SLOT_BITS + BATCH_BITS
) (
    input wire                                      clk,
    input wire                                      reset,
    sched_req_if.issuer                             q,
    output logic [NUM_BANKS-1:0]                    mem_req_valid,
    output mem_bus_pkg::mem_op_e [NUM_BANKS-1:0]    mem_req_op,
    output mem_bus_pkg::byteen_t [NUM_BANKS-1:0]    mem_req_byteen,
    output mem_bus_pkg::addr_t [NUM_BANKS-1:0]      mem_req_addr,
    output mem_bus_pkg::data_t [NUM_BANKS-1:0]      mem_req_data,
    output logic [NUM_BANKS-1:0][MEM_TAGW-1:0]      mem_req_tag,
    input wire [NUM_BANKS-1:0]                      mem_req_ready
);
    logic [BATCH_BITS-1:0] batch_idx;
    logic [NUM_BANKS-1:0]  sent_mask;
    logic [NUM_BANKS-1:0]  sent_mask_n;
    logic [NUM_BANKS-1:0]  batch_mask;
    logic [NUM_BANKS-1:0]  fire;
    logic                  batch_done;
    logic                  more_lanes;

    // Slice the head entry, lanes past NUM_REQS are masked-off padding
    always_comb begin
        int lane;
        batch_mask = '0;
        for (int b = 0; b < NUM_BANKS; b++) begin
            lane = int'(batch_idx) * NUM_BANKS + b;
            mem_req_op[b]  = q.op;
            mem_req_tag[b] = {batch_idx, q.slot};
            if (lane < NUM_REQS) begin
                batch_mask[b]     = q.mask[lane];
                mem_req_byteen[b] = q.byteen[lane];
                mem_req_addr[b]   = q.addr[lane];
                mem_req_data[b]   = q.data[lane];
            end else begin
                mem_req_byteen[b] = '0;
                mem_req_addr[b]   = '0;
                mem_req_data[b]   = '0;
            end
        end
    end

    // Any masked lane beyond the current batch
    always_comb begin
        more_lanes = 1'b0;
        for (int i = 0; i < NUM_REQS; i++) begin
            if (i >= (int'(batch_idx) + 1) * NUM_BANKS) begin
                more_lanes |= q.mask[i];
            end
        end
    end

    assign mem_req_valid = batch_mask & ~sent_mask & {NUM_BANKS{q.valid}};
    assign fire          = mem_req_valid & mem_req_ready;
    assign sent_mask_n   = sent_mask | fire;

    // An empty batch completes at once and is skipped
    assign batch_done = q.valid && (sent_mask_n == batch_mask);
    assign q.pop      = batch_done && !more_lanes;

    always_ff @(posedge clk) begin
        if (reset) begin
            batch_idx <= '0;
            sent_mask <= '0;
        end else if (batch_done) begin
            batch_idx <= q.pop ? '0 : batch_idx + 1'b1;
            sent_mask <= '0;
        end else begin
            sent_mask <= sent_mask_n;
        end
    end

    // Issue state is back at the first batch whenever no head is present
    a_no_issue_idle: assert property (@(posedge clk) disable iff (reset)
        !q.valid |-> (sent_mask == '0) && (batch_idx == '0));

endmodule

`default_nettype wire

//--- request/req_queue.sv
`default_nettype none

module req_queue #(
    parameter int NUM_REQS   = sched_cfg_pkg::DEF_NUM_REQS,
    parameter int QUEUE_SIZE = sched_cfg_pkg::DEF_QUEUE_SIZE,
    localparam int SLOT_BITS = (QUEUE_SIZE > 1) ? $clog2(QUEUE_SIZE) : 1
) (
    input wire                                  clk,
    input wire                                  reset,
    input wire                                  push,
    input wire mem_bus_pkg::mem_op_e            op,
    input wire [NUM_REQS-1:0]                   mask,
    input wire mem_bus_pkg::byteen_t [NUM_REQS-1:0] byteen,
    input wire mem_bus_pkg::addr_t [NUM_REQS-1:0]   addr,
    input wire mem_bus_pkg::data_t [NUM_REQS-1:0]   data,
    input wire [SLOT_BITS-1:0]                  slot,
    output logic                                full,
    output logic                                empty,
    sched_req_if.queue                          q
);
    import mem_bus_pkg::*;

    localparam int CNT_BITS = $clog2(QUEUE_SIZE + 1);

    typedef struct packed {
        mem_op_e                op;
        logic [NUM_REQS-1:0]    mask;
        byteen_t [NUM_REQS-1:0] byteen;
        addr_t [NUM_REQS-1:0]   addr;
        data_t [NUM_REQS-1:0]   data;
        logic [SLOT_BITS-1:0]   slot;
    } entry_t;

    entry_t               entries [QUEUE_SIZE];
    entry_t               in_entry;
    entry_t               head;
    logic [SLOT_BITS-1:0] rd_ptr;
    logic [SLOT_BITS-1:0] rd_ptr_n;
    logic [SLOT_BITS-1:0] wr_ptr;
    logic [CNT_BITS-1:0]  count;
    logic [CNT_BITS-1:0]  kept;
    logic [CNT_BITS-1:0]  count_n;
    logic                 head_valid;
    logic                 pop_fire;

    function automatic logic [SLOT_BITS-1:0] next_ptr(input logic [SLOT_BITS-1:0] p);
        return (p == SLOT_BITS'(QUEUE_SIZE - 1)) ? '0 : p + 1'b1;
    endfunction

    assign in_entry = '{op, mask, byteen, addr, data, slot};
    assign pop_fire = q.pop && head_valid;
    assign rd_ptr_n = pop_fire ? next_ptr(rd_ptr) : rd_ptr;

    // Entries left once the head is gone, the first of them sits at rd_ptr_n
    assign kept    = count - CNT_BITS'(pop_fire);
    assign count_n = kept + CNT_BITS'(push);

    always_ff @(posedge clk) begin
        if (reset) begin
            rd_ptr     <= '0;
            wr_ptr     <= '0;
            count      <= '0;
            head_valid <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            rd_ptr     <= rd_ptr_n;
            count      <= count_n;
            head_valid <= (count_n != '0);
        end
    end

    // Head register, bypassing the array when the queue runs dry
    always_ff @(posedge clk) begin
        if (push) begin
            entries[wr_ptr] <= in_entry;
        end
        head <= (kept == '0) ? in_entry : entries[rd_ptr_n];
    end

    assign full  = (count == CNT_BITS'(QUEUE_SIZE));
    assign empty = (count == '0);

    assign q.valid  = head_valid;
    assign q.op     = head.op;
    assign q.mask   = head.mask;
    assign q.byteen = head.byteen;
    assign q.addr   = head.addr;
    assign q.data   = head.data;
    assign q.slot   = head.slot;

    // Caller handshake must respect the queue level
    a_no_push_full: assert property (@(posedge clk) disable iff (reset) push |-> !full);

endmodule

`default_nettype wire

//--- response/rsp_gather.sv
`default_nettype none

module rsp_gather #(
    parameter int NUM_REQS    = sched_cfg_pkg::DEF_NUM_REQS,
    parameter int NUM_BANKS   = sched_cfg_pkg::DEF_NUM_BANKS,
    parameter int QUEUE_SIZE  = sched_cfg_pkg::DEF_QUEUE_SIZE,
    localparam int NUM_BATCHES = (NUM_REQS + NUM_BANKS - 1) / NUM_BANKS,
    localparam int SLOT_BITS   = (QUEUE_SIZE > 1) ? $clog2(QUEUE_SIZE) : 1,
    localparam int BATCH_BITS  = (NUM_BATCHES > 1) ? $clog2(NUM_BATCHES) : 1,
    localparam int MEM_TAGW    = SLOT_BITS + BATCH_BITS
) (
    input wire                                  clk,
    input wire                                  reset,
    input wire                                  alloc,
    input wire [SLOT_BITS-1:0]                  alloc_slot,
    input wire [NUM_REQS-1:0]                   alloc_mask,
    input wire [NUM_BANKS-1:0]                  mem_rsp_valid,
    input wire mem_bus_pkg::data_t [NUM_BANKS-1:0] mem_rsp_data,
    input wire [NUM_BANKS-1:0][MEM_TAGW-1:0]    mem_rsp_tag,
    output logic [NUM_BANKS-1:0]                mem_rsp_ready,
    output logic [SLOT_BITS-1:0]                rsp_slot,
    input wire mem_bus_pkg::tag_t               tag,
    output logic                                done,
    output logic                                rsp_valid,
    output logic [NUM_REQS-1:0]                 rsp_mask,
    output mem_bus_pkg::data_t [NUM_REQS-1:0]   rsp_data,
    output mem_bus_pkg::tag_t                   rsp_tag,
    output logic                                rsp_eop,
    input wire                                  rsp_ready
);
    import mem_bus_pkg::*;

    localparam int PAD_LANES = NUM_BATCHES * NUM_BANKS;
    localparam int BANK_BITS = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;

    logic [BANK_BITS-1:0]  sel;
    logic                  any_valid;
    logic [MEM_TAGW-1:0]   sel_tag;
    logic [BATCH_BITS-1:0] rsp_batch;
    int                    lane;
    logic [PAD_LANES-1:0]  hit;
    logic [PAD_LANES-1:0]  rem_n;
    logic                  complete;
    logic                  accept;
    data_t [PAD_LANES-1:0] store_n;

    logic [PAD_LANES-1:0]  rem_mask [QUEUE_SIZE];
    logic [NUM_REQS-1:0]   orig_mask [QUEUE_SIZE];
    data_t [PAD_LANES-1:0] store [QUEUE_SIZE];

    // Lowest-numbered valid bank goes first
    always_comb begin
        sel       = '0;
        any_valid = 1'b0;
        for (int b = NUM_BANKS - 1; b >= 0; b--) begin
            if (mem_rsp_valid[b]) begin
                sel       = BANK_BITS'(b);
                any_valid = 1'b1;
            end
        end
    end

    // Memory tag is {batch, slot}
    assign sel_tag   = mem_rsp_tag[sel];
    assign rsp_slot  = sel_tag[SLOT_BITS-1:0];
    assign rsp_batch = sel_tag[SLOT_BITS +: BATCH_BITS];
    assign lane      = int'(rsp_batch) * NUM_BANKS + int'(sel);

    always_comb begin
        hit           = '0;
        hit[lane]     = 1'b1;
        store_n       = store[rsp_slot];
        store_n[lane] = mem_rsp_data[sel];
    end

    assign rem_n    = rem_mask[rsp_slot] & ~hit;
    assign complete = (rem_n == '0);

    // Hold only the response that would finish a slot
    assign accept        = any_valid && (rsp_ready || !complete);
    assign mem_rsp_ready = accept ? (NUM_BANKS'(1) << sel) : '0;

    assign rsp_valid = any_valid && complete;
    assign rsp_eop   = rsp_valid;
    assign done      = rsp_valid && rsp_ready;
    assign rsp_mask  = orig_mask[rsp_slot];
    assign rsp_data  = store_n[NUM_REQS-1:0];
    assign rsp_tag   = tag;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < QUEUE_SIZE; i++) begin
                rem_mask[i] <= '0;
            end
        end else begin
            if (alloc) begin
                rem_mask[alloc_slot] <= PAD_LANES'(alloc_mask);
            end
            if (accept) begin
                rem_mask[rsp_slot] <= rem_n;
            end
        end
    end

    // Cleared store leaves unmasked lanes at zero
    always_ff @(posedge clk) begin
        if (alloc) begin
            orig_mask[alloc_slot] <= alloc_mask;
            store[alloc_slot]     <= '0;
        end
        if (accept) begin
            store[rsp_slot] <= store_n;
        end
    end

    // Banks only answer lanes that are still outstanding
    a_rsp_outstanding: assert property (@(posedge clk) disable iff (reset)
        any_valid |-> ((rem_mask[rsp_slot] & hit) != '0));

endmodule

`default_nettype wire

//--- response/slot_table.sv
`default_nettype none

module slot_table #(
    parameter int QUEUE_SIZE = sched_cfg_pkg::DEF_QUEUE_SIZE,
    localparam int SLOT_BITS = (QUEUE_SIZE > 1) ? $clog2(QUEUE_SIZE) : 1
) (
    input wire                      clk,
    input wire                      reset,
    input wire                      acquire,
    input wire mem_bus_pkg::tag_t   tag_in,
    output logic [SLOT_BITS-1:0]    free_slot,
    input wire                      release_slot,
    input wire [SLOT_BITS-1:0]      slot,
    output mem_bus_pkg::tag_t       tag_out,
    output logic                    full,
    output logic                    empty
);
    import mem_bus_pkg::*;

    logic [QUEUE_SIZE-1:0] busy;
    tag_t                  tags [QUEUE_SIZE];

    // Lowest free slot wins
    always_comb begin
        free_slot = '0;
        for (int i = QUEUE_SIZE - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_slot = SLOT_BITS'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (acquire) begin
                busy[free_slot] <= 1'b1;
            end
            if (release_slot) begin
                busy[slot] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (acquire) begin
            tags[free_slot] <= tag_in;
        end
    end

    assign tag_out = tags[slot];
    assign full    = &busy;
    assign empty   = ~|busy;

    a_no_acquire_full: assert property (@(posedge clk) disable iff (reset) acquire |-> !full);
    a_release_busy: assert property (@(posedge clk) disable iff (reset)
        release_slot |-> busy[slot]);

endmodule

`default_nettype wire

//--- source/mem_scheduler.sv
`default_nettype none

module mem_scheduler #(
    parameter int NUM_REQS    = sched_cfg_pkg::DEF_NUM_REQS,
    parameter int NUM_BANKS   = sched_cfg_pkg::DEF_NUM_BANKS,
    parameter int QUEUE_SIZE  = sched_cfg_pkg::DEF_QUEUE_SIZE,
    localparam int NUM_BATCHES = (NUM_REQS + NUM_BANKS - 1) / NUM_BANKS,
    localparam int SLOT_BITS   = (QUEUE_SIZE > 1) ? $clog2(QUEUE_SIZE) : 1,
    localparam int BATCH_BITS  = (NUM_BATCHES > 1) ? $clog2(NUM_BATCHES) : 1,
    localparam int MEM_TAGW    = SLOT_BITS + BATCH_BITS
) (
    input wire                                      clk,
    input wire                                      reset,
    // Caller request
    input wire                                      req_valid,
    input wire mem_bus_pkg::mem_op_e                req_op,
    input wire [NUM_REQS-1:0]                       req_mask,
    input wire mem_bus_pkg::byteen_t [NUM_REQS-1:0] req_byteen,
    input wire mem_bus_pkg::addr_t [NUM_REQS-1:0]   req_addr,
    input wire mem_bus_pkg::data_t [NUM_REQS-1:0]   req_data,
    input wire mem_bus_pkg::tag_t                   req_tag,
    output wire                                     req_ready,
    output wire                                     req_empty,
    // Caller response
    output wire                                     rsp_valid,
    output wire [NUM_REQS-1:0]                      rsp_mask,
    output wire mem_bus_pkg::data_t [NUM_REQS-1:0]  rsp_data,
    output wire mem_bus_pkg::tag_t                  rsp_tag,
    output wire                                     rsp_eop,
    input wire                                      rsp_ready,
    // Bank requests
    output wire [NUM_BANKS-1:0]                     mem_req_valid,
    output wire mem_bus_pkg::mem_op_e [NUM_BANKS-1:0] mem_req_op,
    output wire mem_bus_pkg::byteen_t [NUM_BANKS-1:0] mem_req_byteen,
    output wire mem_bus_pkg::addr_t [NUM_BANKS-1:0] mem_req_addr,
    output wire mem_bus_pkg::data_t [NUM_BANKS-1:0] mem_req_data,
    output wire [NUM_BANKS-1:0][MEM_TAGW-1:0]       mem_req_tag,
    input wire [NUM_BANKS-1:0]                      mem_req_ready,
    // Bank responses
    input wire [NUM_BANKS-1:0]                      mem_rsp_valid,
    input wire mem_bus_pkg::data_t [NUM_BANKS-1:0]  mem_rsp_data,
    input wire [NUM_BANKS-1:0][MEM_TAGW-1:0]        mem_rsp_tag,
    output wire [NUM_BANKS-1:0]                     mem_rsp_ready
);
    import mem_bus_pkg::*;

    wire                  push;
    wire                  acquire;
    wire                  q_full;
    wire                  q_empty;
    wire                  st_full;
    wire                  st_empty;
    wire [SLOT_BITS-1:0]  free_slot;
    wire [SLOT_BITS-1:0]  rsp_slot;
    wire tag_t            slot_tag;
    wire                  rsp_done;

    sched_req_if #(.NUM_REQS(NUM_REQS), .QUEUE_SIZE(QUEUE_SIZE)) req_if ();

    // Writes need no slot
    assign req_ready = !q_full && ((req_op == MEM_WRITE) || !st_full);
    assign req_empty = q_empty && st_empty;
    assign push      = req_valid && req_ready;
    assign acquire   = push && (req_op == MEM_READ);

    req_queue #(.NUM_REQS(NUM_REQS), .QUEUE_SIZE(QUEUE_SIZE)) req_queue_i (
        .clk(clk), .reset(reset), .push(push), .op(req_op), .mask(req_mask),
        .byteen(req_byteen), .addr(req_addr), .data(req_data), .slot(free_slot),
        .full(q_full), .empty(q_empty), .q(req_if)
    );

    batch_issuer #(.NUM_REQS(NUM_REQS), .NUM_BANKS(NUM_BANKS), .QUEUE_SIZE(QUEUE_SIZE))
    batch_issuer_i (
        .clk(clk), .reset(reset), .q(req_if), .mem_req_valid(mem_req_valid),
        .mem_req_op(mem_req_op), .mem_req_byteen(mem_req_byteen),
        .mem_req_addr(mem_req_addr), .mem_req_data(mem_req_data),
        .mem_req_tag(mem_req_tag), .mem_req_ready(mem_req_ready)
    );

    slot_table #(.QUEUE_SIZE(QUEUE_SIZE)) slot_table_i (
        .clk(clk), .reset(reset), .acquire(acquire), .tag_in(req_tag),
        .free_slot(free_slot), .release_slot(rsp_done), .slot(rsp_slot),
        .tag_out(slot_tag), .full(st_full), .empty(st_empty)
    );

    rsp_gather #(.NUM_REQS(NUM_REQS), .NUM_BANKS(NUM_BANKS), .QUEUE_SIZE(QUEUE_SIZE))
    rsp_gather_i (
        .clk(clk), .reset(reset), .alloc(acquire), .alloc_slot(free_slot),
        .alloc_mask(req_mask), .mem_rsp_valid(mem_rsp_valid), .mem_rsp_data(mem_rsp_data),
        .mem_rsp_tag(mem_rsp_tag), .mem_rsp_ready(mem_rsp_ready), .rsp_slot(rsp_slot),
        .tag(slot_tag), .done(rsp_done), .rsp_valid(rsp_valid), .rsp_mask(rsp_mask),
        .rsp_data(rsp_data), .rsp_tag(rsp_tag), .rsp_eop(rsp_eop), .rsp_ready(rsp_ready)
    );

endmodule

`default_nettype wire

//--- verif/mem_scheduler_tb.sv
`default_nettype none

module mem_scheduler_tb;
    import mem_bus_pkg::*;
    import sched_cfg_pkg::*;

    localparam int NUM_REQS    = DEF_NUM_REQS;
    localparam int NUM_BANKS   = DEF_NUM_BANKS;
    localparam int QUEUE_SIZE  = DEF_QUEUE_SIZE;
    localparam int NUM_BATCHES = (NUM_REQS + NUM_BANKS - 1) / NUM_BANKS;
    localparam int SLOT_BITS   = (QUEUE_SIZE > 1) ? $clog2(QUEUE_SIZE) : 1;
    localparam int BATCH_BITS  = (NUM_BATCHES > 1) ? $clog2(NUM_BATCHES) : 1;
    localparam int MEM_TAGW    = SLOT_BITS + BATCH_BITS;
    localparam int N_WRITES    = 8;
    localparam int N_RANDOM    = 40;
    // Two directed reads, writes with their read-back, then random reads
    localparam int TOTAL_REQS  = 2 + 2 * N_WRITES + N_RANDOM;

    typedef logic [NUM_REQS-1:0]    mask_t;
    typedef addr_t [NUM_REQS-1:0]   addr_lanes_t;
    typedef data_t [NUM_REQS-1:0]   data_lanes_t;
    typedef byteen_t [NUM_REQS-1:0] byteen_lanes_t;

    typedef struct {
        mem_op_e       op;
        mask_t         mask;
        addr_lanes_t   addr;
        data_lanes_t   data;
        byteen_lanes_t byteen;
    } issued_t;

    typedef struct {
        data_t               data;
        logic [MEM_TAGW-1:0] tag;
        int                  due;
    } pending_t;

    logic clk;
    logic reset;
    logic req_valid;
    mem_op_e req_op;
    mask_t req_mask;
    byteen_lanes_t req_byteen;
    addr_lanes_t req_addr;
    data_lanes_t req_data;
    tag_t req_tag;
    logic req_ready;
    logic req_empty;
    logic rsp_valid;
    mask_t rsp_mask;
    data_lanes_t rsp_data;
    tag_t rsp_tag;
    logic rsp_eop;
    logic rsp_ready;
    logic [NUM_BANKS-1:0] mem_req_valid;
    mem_op_e [NUM_BANKS-1:0] mem_req_op;
    byteen_t [NUM_BANKS-1:0] mem_req_byteen;
    addr_t [NUM_BANKS-1:0] mem_req_addr;
    data_t [NUM_BANKS-1:0] mem_req_data;
    logic [NUM_BANKS-1:0][MEM_TAGW-1:0] mem_req_tag;
    logic [NUM_BANKS-1:0] mem_req_ready;
    logic [NUM_BANKS-1:0] mem_rsp_valid;
    data_t [NUM_BANKS-1:0] mem_rsp_data;
    logic [NUM_BANKS-1:0][MEM_TAGW-1:0] mem_rsp_tag;
    logic [NUM_BANKS-1:0] mem_rsp_ready;

    integer seed = 54466;

    // Shadow memory and expected responses by caller tag
    data_t       shadow [addr_t];
    data_lanes_t exp_data [tag_t];
    mask_t       exp_mask [tag_t];
    issued_t     issue_q [$];
    mask_t       sent;
    pending_t    pend [NUM_BANKS][$];
    int          cycle;

    mem_scheduler #(.NUM_REQS(NUM_REQS), .NUM_BANKS(NUM_BANKS), .QUEUE_SIZE(QUEUE_SIZE))
    mem_scheduler_i (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Untouched words hold a pattern of their own address
    function automatic data_t mem_read(input addr_t a);
        if (shadow.exists(a)) begin
            return shadow[a];
        end
        return {a[15:0], a[31:16]} ^ 32'h3c5a_96e1;
    endfunction

    function automatic data_t merge_bytes(input data_t old, input data_t wdata, input byteen_t be);
        data_t r;
        r = old;
        for (int k = 0; k < BYTEEN_WIDTH; k++) begin
            if (be[k]) begin
                r[8*k +: 8] = wdata[8*k +: 8];
            end
        end
        return r;
    endfunction

    function automatic data_lanes_t expected_read(input addr_lanes_t a, input mask_t m);
        data_lanes_t r;
        for (int i = 0; i < NUM_REQS; i++) begin
            r[i] = m[i] ? mem_read(a[i]) : '0;
        end
        return r;
    endfunction

    function automatic mask_t random_mask();
        mask_t m;
        m = mask_t'($random(seed));
        if (m == '0) begin
            m = mask_t'(1);
        end
        return m;
    endfunction

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at time %0t: %s, got %0h, expected %0h",
                $time, what, got, exp));
        end
    endtask

    task automatic send_request(input mem_op_e op, input mask_t mask, input addr_lanes_t addr,
                                input data_lanes_t data, input byteen_lanes_t byteen,
                                input tag_t tag);
        issued_t item;
        @(posedge clk);
        req_valid  <= 1'b1;
        req_op     <= op;
        req_mask   <= mask;
        req_addr   <= addr;
        req_data   <= data;
        req_byteen <= byteen;
        req_tag    <= tag;
        do @(posedge clk); while (!req_ready);
        req_valid <= 1'b0;
        item.op     = op;
        item.mask   = mask;
        item.addr   = addr;
        item.data   = data;
        item.byteen = byteen;
        issue_q.push_back(item);
        if (op == MEM_READ) begin
            exp_data[tag] = expected_read(addr, mask);
            exp_mask[tag] = mask;
        end
    endtask

    task automatic wait_idle();
        do @(posedge clk); while (!req_empty);
    endtask

    always @(posedge clk) begin
        if (reset) begin
            mem_req_ready <= '0;
            rsp_ready     <= 1'b0;
        end else begin
            for (int b = 0; b < NUM_BANKS; b++) begin
                mem_req_ready[b] <= (($random(seed) & 3) != 0);
            end
            rsp_ready <= (($random(seed) & 3) != 0);
        end
    end

    // Bank model, also checks every lane as it fires
    always @(posedge clk) begin
        int lane;
        pending_t item;
        if (reset) begin
            mem_rsp_valid <= '0;
            cycle = 0;
            sent = '0;
        end else begin
            cycle++;
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (mem_rsp_valid[b] && mem_rsp_ready[b]) begin
                    void'(pend[b].pop_front());
                end
            end
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (mem_req_valid[b] && mem_req_ready[b]) begin
                    lane = int'(mem_req_tag[b][MEM_TAGW-1:SLOT_BITS]) * NUM_BANKS + b;
                    if (issue_q.size() == 0) begin
                        stop_with_error("A bank request fired with no request in flight");
                    end
                    if (lane >= NUM_REQS) begin
                        stop_with_error("A bank request fired on a padding lane");
                    end
                    check_value(issue_q[0].mask[lane], 1, "lane mask at bank fire");
                    check_value(sent[lane], 0, "lane fired twice");
                    check_value(mem_req_op[b], issue_q[0].op, "bank opcode");
                    check_value(mem_req_addr[b], issue_q[0].addr[lane], "bank address");
                    if (issue_q[0].op == MEM_WRITE) begin
                        check_value(mem_req_data[b], issue_q[0].data[lane], "bank write data");
                        check_value(mem_req_byteen[b], issue_q[0].byteen[lane], "bank byteen");
                        shadow[mem_req_addr[b]] = merge_bytes(mem_read(mem_req_addr[b]),
                            mem_req_data[b], mem_req_byteen[b]);
                    end else begin
                        item.data = mem_read(mem_req_addr[b]);
                        item.tag  = mem_req_tag[b];
                        item.due  = cycle + 1 + ($random(seed) & 7);
                        pend[b].push_back(item);
                    end
                    sent[lane] = 1'b1;
                end
            end
            if (issue_q.size() != 0 && sent == issue_q[0].mask) begin
                void'(issue_q.pop_front());
                sent = '0;
            end
            for (int b = 0; b < NUM_BANKS; b++) begin
                if (pend[b].size() != 0 && pend[b][0].due <= cycle) begin
                    mem_rsp_valid[b] <= 1'b1;
                    mem_rsp_data[b]  <= pend[b][0].data;
                    mem_rsp_tag[b]   <= pend[b][0].tag;
                end else begin
                    mem_rsp_valid[b] <= 1'b0;
                end
            end
        end
    end

    // Response compare against the entry kept for the tag
    always @(posedge clk) begin
        if (!reset && rsp_valid && rsp_ready) begin
            if (!exp_mask.exists(rsp_tag)) begin
                stop_with_error($sformatf("Response with tag %0h that no read is waiting for",
                    rsp_tag));
            end
            check_value(rsp_mask, exp_mask[rsp_tag], "response mask");
            check_value(rsp_eop, 1, "response eop");
            for (int i = 0; i < NUM_REQS; i++) begin
                check_value(rsp_data[i], exp_data[rsp_tag][i],
                    $sformatf("lane %0d data of tag %0h", i, rsp_tag));
            end
            exp_mask.delete(rsp_tag);
            exp_data.delete(rsp_tag);
        end
    end

    initial begin
        repeat (5 + 400 * TOTAL_REQS) @(posedge clk);
        stop_with_error("Timeout, the tests did not finish in time");
    end

    initial begin
        addr_lanes_t   addr;
        data_lanes_t   data;
        byteen_lanes_t byteen;
        addr_lanes_t   wr_addr [N_WRITES];
        reset         <= 1'b1;
        req_valid     <= 1'b0;
        req_op        <= MEM_READ;
        req_mask      <= '0;
        req_byteen    <= '0;
        req_addr      <= '0;
        req_data      <= '0;
        req_tag       <= '0;
        rsp_ready     <= 1'b0;
        mem_req_ready <= '0;
        mem_rsp_valid <= '0;
        mem_rsp_data  <= '0;
        mem_rsp_tag   <= '0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(posedge clk);
        check_value(req_ready, 1, "req_ready after reset");
        check_value(req_empty, 1, "req_empty after reset");
        check_value(rsp_valid, 0, "rsp_valid after reset");
        check_value(mem_req_valid, 0, "mem_req_valid after reset");

        data   = '0;
        byteen = '0;
        for (int i = 0; i < NUM_REQS; i++) begin
            addr[i] = 32'h0000_1000 + 4 * i;
        end
        send_request(MEM_READ, '1, addr, data, byteen, 8'd1);
        for (int i = 0; i < NUM_REQS; i++) begin
            addr[i] = 32'h0000_2000 + 8 * i;
        end
        send_request(MEM_READ, mask_t'(6'b010110), addr, data, byteen, 8'd2);
        wait_idle();

        // Byte-enabled writes, then read the same words back
        for (int w = 0; w < N_WRITES; w++) begin
            for (int i = 0; i < NUM_REQS; i++) begin
                wr_addr[w][i] = 32'h0001_0000 + 64 * w + 4 * i;
                data[i]       = $random(seed);
                byteen[i]     = byteen_t'($random(seed));
            end
            send_request(MEM_WRITE, random_mask(), wr_addr[w], data, byteen, 8'd0);
        end
        wait_idle();
        data   = '0;
        byteen = '0;
        for (int w = 0; w < N_WRITES; w++) begin
            send_request(MEM_READ, '1, wr_addr[w], data, byteen, tag_t'(16 + w));
        end
        wait_idle();

        for (int r = 0; r < N_RANDOM; r++) begin
            for (int i = 0; i < NUM_REQS; i++) begin
                addr[i] = addr_t'($random(seed)) & 32'hffff_fffc;
            end
            send_request(MEM_READ, random_mask(), addr, data, byteen, tag_t'(32 + r));
        end
        wait_idle();
        repeat (10) @(posedge clk);

        if (exp_mask.num() != 0 || issue_q.size() != 0) begin
            stop_with_error("Some requests were still waiting at the end of the run");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule

`default_nettype wire
